// ==== rv_pkg.sv ====
package rv_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [6:0] {
    OP_LW    = 7'b0000011,
    OP_SW    = 7'b0100011,
    OP_RTYPE = 7'b0110011,
    OP_ITYPE = 7'b0010011,
    OP_BEQ   = 7'b1100011,
    OP_JAL   = 7'b1101111
  } opcode_t;

  typedef enum logic [3:0] {
    S_FETCH    = 4'd0, // Zero so an uninitialized register starts here
    S_DECODE   = 4'd1,
    S_MEMADR   = 4'd2,
    S_MEMREAD  = 4'd3,
    S_MEMWB    = 4'd4,
    S_MEMWRITE = 4'd5,
    S_EXECR    = 4'd6,
    S_EXECI    = 4'd7,
    S_ALUWB    = 4'd8,
    S_BEQ      = 4'd9,
    S_JAL      = 4'd10
  } fsm_state_t;

  typedef enum logic [1:0] {
    ALUOP_ADD   = 2'd0,
    ALUOP_SUB   = 2'd1,
    ALUOP_FUNCT = 2'd2 // Let funct3/funct7 pick the operation
  } alu_op_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_ctrl_t;

  typedef enum logic {
    ADR_SRC_PC     = 1'b0,
    ADR_SRC_RESULT = 1'b1
  } adr_src_t;

  typedef enum logic [1:0] {
    ALU_SRC_A_PC     = 2'd0,
    ALU_SRC_A_OLD_PC = 2'd1,
    ALU_SRC_A_RD1    = 2'd2
  } alu_src_a_t;

  typedef enum logic [1:0] {
    ALU_SRC_B_RD2 = 2'd0,
    ALU_SRC_B_IMM = 2'd1,
    ALU_SRC_B_4   = 2'd2
  } alu_src_b_t;

  typedef enum logic [1:0] {
    RESULT_SRC_ALU_OUT    = 2'd0,
    RESULT_SRC_DATA       = 2'd1,
    RESULT_SRC_ALU_RESULT = 2'd2 // Live ALU output that bypasses alu_out
  } result_src_t;

  typedef struct packed {
    adr_src_t    adr_src;
    logic        ir_write;
    logic        reg_write;
    logic        pc_update;
    logic        mem_write;
    alu_src_a_t  alu_src_a;
    alu_src_b_t  alu_src_b;
    result_src_t result_src;
    alu_op_t     alu_op;
  } ctrl_t;

endpackage

// ==== alu.sv ====
`timescale 1ns/1ns

module alu (
  input  rv_pkg::data_t     a,
  input  rv_pkg::data_t     b,
  input  rv_pkg::alu_ctrl_t op,
  output rv_pkg::data_t     y,
  output logic              zero
);

  logic lt;

  assign lt = $signed(a) < $signed(b); // Signed compare for slt

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD: y = a + b;
      rv_pkg::ALU_SUB: y = a - b;
      rv_pkg::ALU_AND: y = a & b;
      rv_pkg::ALU_OR:  y = a | b;
      rv_pkg::ALU_SLT: y = {31'b0, lt};
      default:         y = a + b;
    endcase
  end

  assign zero = (y == '0);

endmodule

// ==== fetch.sv ====
`timescale 1ns/1ns

module fetch (
  input  logic          clk,
  input  logic          rst_n,
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::data_t result,
  output rv_pkg::addr_t pc,
  output rv_pkg::addr_t old_pc
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (ctrl.pc_update) begin
      pc <= result;
    end
  end

  // PC of the instruction now in the IR
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      old_pc <= '0;
    end else if (ctrl.ir_write) begin
      old_pc <= pc;
    end
  end

endmodule

// ==== control_fsm.sv ====
`timescale 1ns/1ns

module control_fsm (
  input  logic            clk,
  input  logic            rst_n,
  input  rv_pkg::opcode_t opcode,
  input  logic            zero,
  output rv_pkg::ctrl_t   ctrl
);

  rv_pkg::fsm_state_t state;
  rv_pkg::fsm_state_t state_nxt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= rv_pkg::S_FETCH;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = rv_pkg::S_FETCH;
    case (state)
      rv_pkg::S_FETCH:   state_nxt = rv_pkg::S_DECODE;
      rv_pkg::S_DECODE: begin
        case (opcode)
          rv_pkg::OP_LW,
          rv_pkg::OP_SW:    state_nxt = rv_pkg::S_MEMADR;
          rv_pkg::OP_RTYPE: state_nxt = rv_pkg::S_EXECR;
          rv_pkg::OP_ITYPE: state_nxt = rv_pkg::S_EXECI;
          rv_pkg::OP_BEQ:   state_nxt = rv_pkg::S_BEQ;
          rv_pkg::OP_JAL:   state_nxt = rv_pkg::S_JAL;
          default:          state_nxt = rv_pkg::S_FETCH; // Unknown opcode is skipped
        endcase
      end
      rv_pkg::S_MEMADR: begin
        state_nxt = (opcode == rv_pkg::OP_LW) ? rv_pkg::S_MEMREAD : rv_pkg::S_MEMWRITE;
      end
      rv_pkg::S_MEMREAD: state_nxt = rv_pkg::S_MEMWB;
      rv_pkg::S_EXECR,
      rv_pkg::S_EXECI,
      rv_pkg::S_JAL:     state_nxt = rv_pkg::S_ALUWB;
      default:           state_nxt = rv_pkg::S_FETCH;
    endcase
  end

  always_comb begin
    ctrl.adr_src    = rv_pkg::ADR_SRC_PC;
    ctrl.ir_write   = 1'b0;
    ctrl.reg_write  = 1'b0;
    ctrl.pc_update  = 1'b0;
    ctrl.mem_write  = 1'b0;
    ctrl.alu_src_a  = rv_pkg::ALU_SRC_A_PC;
    ctrl.alu_src_b  = rv_pkg::ALU_SRC_B_RD2;
    ctrl.result_src = rv_pkg::RESULT_SRC_ALU_OUT;
    ctrl.alu_op     = rv_pkg::ALUOP_ADD;
    case (state)
      rv_pkg::S_FETCH: begin
        ctrl.ir_write   = 1'b1;
        ctrl.pc_update  = 1'b1; // pc + 4 straight from the ALU
        ctrl.alu_src_b  = rv_pkg::ALU_SRC_B_4;
        ctrl.result_src = rv_pkg::RESULT_SRC_ALU_RESULT;
      end
      rv_pkg::S_DECODE: begin
        ctrl.alu_src_a = rv_pkg::ALU_SRC_A_OLD_PC; // Branch or jump target into alu_out
        ctrl.alu_src_b = rv_pkg::ALU_SRC_B_IMM;
      end
      rv_pkg::S_MEMADR: begin
        ctrl.alu_src_a = rv_pkg::ALU_SRC_A_RD1;
        ctrl.alu_src_b = rv_pkg::ALU_SRC_B_IMM;
      end
      rv_pkg::S_MEMREAD:  ctrl.adr_src = rv_pkg::ADR_SRC_RESULT;
      rv_pkg::S_MEMWB: begin
        ctrl.reg_write  = 1'b1;
        ctrl.result_src = rv_pkg::RESULT_SRC_DATA;
      end
      rv_pkg::S_MEMWRITE: begin
        ctrl.adr_src   = rv_pkg::ADR_SRC_RESULT;
        ctrl.mem_write = 1'b1;
      end
      rv_pkg::S_EXECR: begin
        ctrl.alu_src_a = rv_pkg::ALU_SRC_A_RD1;
        ctrl.alu_op    = rv_pkg::ALUOP_FUNCT;
      end
      rv_pkg::S_EXECI: begin
        ctrl.alu_src_a = rv_pkg::ALU_SRC_A_RD1;
        ctrl.alu_src_b = rv_pkg::ALU_SRC_B_IMM;
        ctrl.alu_op    = rv_pkg::ALUOP_FUNCT;
      end
      rv_pkg::S_ALUWB:    ctrl.reg_write = 1'b1;
      rv_pkg::S_BEQ: begin
        ctrl.alu_src_a = rv_pkg::ALU_SRC_A_RD1;
        ctrl.alu_op    = rv_pkg::ALUOP_SUB;
        ctrl.pc_update = zero; // Taken only when rs1 == rs2
      end
      rv_pkg::S_JAL: begin
        ctrl.pc_update = 1'b1;
        ctrl.alu_src_a = rv_pkg::ALU_SRC_A_OLD_PC; // Link value old_pc + 4
        ctrl.alu_src_b = rv_pkg::ALU_SRC_B_4;
      end
      default: ;
    endcase
    if (!rst_n) begin // Enables stay off until reset is released
      ctrl.ir_write  = 1'b0;
      ctrl.reg_write = 1'b0;
      ctrl.pc_update = 1'b0;
      ctrl.mem_write = 1'b0;
    end
  end

endmodule

// ==== instr_decode.sv ====
`timescale 1ns/1ns

module instr_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  rv_pkg::ctrl_t     ctrl,
  input  rv_pkg::data_t     mem_rdata,
  input  rv_pkg::data_t     result,
  output rv_pkg::opcode_t   opcode,
  output rv_pkg::alu_ctrl_t alu_ctrl,
  output rv_pkg::data_t     rd1,
  output rv_pkg::data_t     rd2,
  output rv_pkg::data_t     imm_ext
);

  rv_pkg::instr_t   ir;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  logic [2:0]       funct3;
  rv_pkg::data_t    regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ir <= '0;
    end else if (ctrl.ir_write) begin
      ir <= mem_rdata;
    end
  end

  assign opcode = rv_pkg::opcode_t'(ir[6:0]);
  assign rd     = ir[11:7];
  assign funct3 = ir[14:12];
  assign rs1    = ir[19:15];
  assign rs2    = ir[24:20];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_write && rd != '0) begin // x0 stays zero
      regs[rd] <= result;
    end
  end

  assign rd1 = regs[rs1];
  assign rd2 = regs[rs2];

  always_comb begin
    case (opcode)
      rv_pkg::OP_LW,
      rv_pkg::OP_ITYPE: imm_ext = {{20{ir[31]}}, ir[31:20]};
      rv_pkg::OP_SW:    imm_ext = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      rv_pkg::OP_BEQ:   imm_ext = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
      rv_pkg::OP_JAL:   imm_ext = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
      default:          imm_ext = '0;
    endcase
  end

  always_comb begin
    case (ctrl.alu_op)
      rv_pkg::ALUOP_SUB: alu_ctrl = rv_pkg::ALU_SUB;
      rv_pkg::ALUOP_FUNCT: begin
        case (funct3)
          3'b000: begin
            // funct7[5] means sub, but only for R-type
            if (opcode == rv_pkg::OP_RTYPE && ir[30]) begin
              alu_ctrl = rv_pkg::ALU_SUB;
            end else begin
              alu_ctrl = rv_pkg::ALU_ADD;
            end
          end
          3'b010:  alu_ctrl = rv_pkg::ALU_SLT;
          3'b110:  alu_ctrl = rv_pkg::ALU_OR;
          3'b111:  alu_ctrl = rv_pkg::ALU_AND;
          default: alu_ctrl = rv_pkg::ALU_ADD;
        endcase
      end
      default:           alu_ctrl = rv_pkg::ALU_ADD;
    endcase
  end

endmodule

// ==== operand_select.sv ====
`timescale 1ns/1ns

module operand_select (
  input  logic          clk,
  input  logic          rst_n,
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::addr_t pc,
  input  rv_pkg::addr_t old_pc,
  input  rv_pkg::data_t rd1,
  input  rv_pkg::data_t rd2,
  input  rv_pkg::data_t imm_ext,
  input  rv_pkg::data_t alu_y,
  input  rv_pkg::data_t mem_rdata,
  output rv_pkg::data_t alu_a,
  output rv_pkg::data_t alu_b,
  output rv_pkg::addr_t mem_addr,
  output rv_pkg::data_t result
);

  rv_pkg::data_t alu_out;
  rv_pkg::data_t mem_data;

  always_comb begin
    case (ctrl.alu_src_a)
      rv_pkg::ALU_SRC_A_OLD_PC: alu_a = old_pc;
      rv_pkg::ALU_SRC_A_RD1:    alu_a = rd1;
      default:                  alu_a = pc;
    endcase
  end

  always_comb begin
    case (ctrl.alu_src_b)
      rv_pkg::ALU_SRC_B_IMM: alu_b = imm_ext;
      rv_pkg::ALU_SRC_B_4:   alu_b = 32'd4;
      default:               alu_b = rd2;
    endcase
  end

  // Hold values across state boundaries
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      alu_out  <= '0;
      mem_data <= '0;
    end else begin
      alu_out  <= alu_y;
      mem_data <= mem_rdata;
    end
  end

  assign mem_addr = (ctrl.adr_src == rv_pkg::ADR_SRC_RESULT) ? alu_out : pc;

  always_comb begin
    case (ctrl.result_src)
      rv_pkg::RESULT_SRC_DATA:       result = mem_data;
      rv_pkg::RESULT_SRC_ALU_RESULT: result = alu_y;
      default:                       result = alu_out;
    endcase
  end

endmodule

// ==== unified_mem.sv ====
`timescale 1ns/1ns

module unified_mem #(
  parameter int MEM_WORDS = 256
) (
  input  logic          clk,
  input  rv_pkg::addr_t addr,
  input  rv_pkg::data_t wdata,
  input  logic          we,
  input  logic          load_en,
  input  rv_pkg::addr_t load_addr,
  input  rv_pkg::data_t load_data,
  output rv_pkg::data_t rdata
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  rv_pkg::data_t mem [MEM_WORDS];

  // Word index from the bits above the byte offset
  assign rdata = mem[addr[IDX_W+1:2]];

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr[IDX_W+1:2]] <= load_data; // Program load wins
    end else if (we) begin
      mem[addr[IDX_W+1:2]] <= wdata;
    end
  end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top #(
  parameter int MEM_WORDS = 256
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          load_en,
  input  rv_pkg::addr_t load_addr,
  input  rv_pkg::data_t load_data,
  output logic          store_en,
  output rv_pkg::addr_t store_addr,
  output rv_pkg::data_t store_data
);

  rv_pkg::ctrl_t     ctrl;
  rv_pkg::opcode_t   opcode;
  rv_pkg::alu_ctrl_t alu_ctrl;
  rv_pkg::addr_t     pc;
  rv_pkg::addr_t     old_pc;
  rv_pkg::addr_t     mem_addr;
  rv_pkg::data_t     mem_rdata;
  rv_pkg::data_t     rd1;
  rv_pkg::data_t     rd2;
  rv_pkg::data_t     imm_ext;
  rv_pkg::data_t     alu_a;
  rv_pkg::data_t     alu_b;
  rv_pkg::data_t     alu_y;
  rv_pkg::data_t     result;
  logic              zero;

  control_fsm control_fsm_i
    ( .clk    ( clk    ), .rst_n ( rst_n ), .opcode ( opcode )
    , .zero   ( zero   ), .ctrl  ( ctrl  )
    );

  fetch fetch_i
    ( .clk    ( clk    ), .rst_n ( rst_n ), .ctrl   ( ctrl   )
    , .result ( result ), .pc    ( pc    ), .old_pc ( old_pc )
    );

  instr_decode instr_decode_i
    ( .clk       ( clk       ), .rst_n  ( rst_n  ), .ctrl     ( ctrl     )
    , .mem_rdata ( mem_rdata ), .result ( result ), .opcode   ( opcode   )
    , .alu_ctrl  ( alu_ctrl  ), .rd1    ( rd1    ), .rd2      ( rd2      )
    , .imm_ext   ( imm_ext   )
    );

  alu alu_i
    ( .a ( alu_a ), .b ( alu_b ), .op ( alu_ctrl ), .y ( alu_y ), .zero ( zero ) );

  operand_select operand_select_i
    ( .clk     ( clk     ), .rst_n     ( rst_n     ), .ctrl     ( ctrl     )
    , .pc      ( pc      ), .old_pc    ( old_pc    ), .rd1      ( rd1      )
    , .rd2     ( rd2     ), .imm_ext   ( imm_ext   ), .alu_y    ( alu_y    )
    , .mem_rdata ( mem_rdata ), .alu_a ( alu_a     ), .alu_b    ( alu_b    )
    , .mem_addr  ( mem_addr  ), .result ( result   )
    );

  unified_mem #(.MEM_WORDS(MEM_WORDS)) unified_mem_i // Instructions and data
    ( .clk       ( clk       ), .addr      ( mem_addr  ), .wdata ( rd2       )
    , .we        ( ctrl.mem_write ), .load_en ( load_en ), .load_addr ( load_addr )
    , .load_data ( load_data ), .rdata     ( mem_rdata )
    );

  assign store_en   = ctrl.mem_write;
  assign store_addr = mem_addr;
  assign store_data = rd2;

endmodule

// ==== tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;

  logic          clk;
  logic          rst_n;
  logic          load_en;
  rv_pkg::addr_t load_addr;
  rv_pkg::data_t load_data;
  logic          store_en;
  rv_pkg::addr_t store_addr;
  rv_pkg::data_t store_data;

  rv_pkg::addr_t exp_addr [$];
  rv_pkg::data_t exp_data [$];
  int            n_stores;
  int            stores_seen;

  cpu_top #(.MEM_WORDS(256)) cpu_top_i (.*);

  always #20 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  initial begin
    int          fd;
    string       line;
    byte         tag;
    logic [31:0] a;
    logic [31:0] d;
    clk         = 1'b0;
    rst_n       = 1'b0;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    stores_seen = 0;
    fd = $fopen("cpu_trace.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the trace file cpu_trace.txt");
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line[0] != "#") begin
        void'($sscanf(line, "%c %h %h", tag, a, d));
        if (tag == "P") begin
          @(posedge clk);
          load_en   <= 1'b1; // Program word goes in while the CPU is held in reset
          load_addr <= a;
          load_data <= d;
        end else if (tag == "S") begin
          exp_addr.push_back(a);
          exp_data.push_back(d);
        end
      end
    end
    $fclose(fd);
    n_stores = exp_addr.size();
    @(posedge clk);
    load_en <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    while (stores_seen < n_stores) @(posedge clk);
    repeat (20) @(posedge clk); // Quiet window in which the jal loop must not store
    $display("Verification passed");
    $finish;
  end

  // Store port is settled half a cycle after the state changes
  always @(negedge clk) begin
    if (rst_n && store_en) begin
      assert (exp_addr.size() > 0) else begin
        abort_run($sformatf("Unexpected extra store to %h at %0t ns", store_addr, $time));
      end
      assert (store_addr == exp_addr[0]) else begin
        abort_run($sformatf("** Error at %0t ns: store %0d address expected %h, got %h",
                            $time, stores_seen, exp_addr[0], store_addr));
      end
      assert (store_data == exp_data[0]) else begin
        abort_run($sformatf("** Error at %0t ns: store %0d data expected %h, got %h",
                            $time, stores_seen, exp_data[0], store_data));
      end
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
      stores_seen++;
    end
  end

  initial begin
    @(posedge rst_n);
    #(n_stores * 40 * 40); // 40 cycles of 40 ns per expected store
    abort_run("Timeout: the program did not reach all expected stores");
  end

endmodule

// ==== cpu_trace.txt ====
# P <byte address> <instruction word>, program image loaded in order
# S <byte address> <data word>, expected stores in program order
P 00000000 00600093
P 00000004 FFD00113
P 00000008 002081B3
P 0000000C 20302023
P 00000010 40208233
P 00000014 20402223
P 00000018 0020F2B3
P 0000001C 20502423
P 00000020 0020E333
P 00000024 20602623
P 00000028 001123B3
P 0000002C 20702823
P 00000030 20C02403
P 00000034 001404B3
P 00000038 20902A23
P 0000003C 00108463
P 00000040 20102C23
P 00000044 00208463
P 00000048 20202E23
P 0000004C 0080056F
P 00000050 22102023
P 00000054 22A02223
P 00000058 00700013
P 0000005C 22002423
P 00000060 0000006F
S 00000200 00000003
S 00000204 00000009
S 00000208 00000004
S 0000020C FFFFFFFF
S 00000210 00000001
S 00000214 00000005
S 0000021C FFFFFFFD
S 00000224 00000050
S 00000228 00000000

// ==== sources.f ====
rv_pkg.sv
alu.sv
fetch.sv
control_fsm.sv
instr_decode.sv
operand_select.sv
unified_mem.sv
cpu_top.sv
tb_cpu.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --timescale 1ns/1ns --top-module tb_cpu -f sources.f
	@out="$$(./obj_dir/Vtb_cpu)"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
